// File: vmul_unit.f
logic/vmul_pkg.sv
logic/vmul_insn_queue.sv
logic/vmul_issue.sv
logic/vmul_simd_mul.sv
logic/vmul_result_queue.sv
logic/vmul_unit.sv
tests/tb_clk_rst_gen.sv
tests/tb_vmul_unit.sv

// File: Bender.yml
package:
  name: vmul_unit

sources:
  - files:
      - logic/vmul_pkg.sv
      - logic/vmul_insn_queue.sv
      - logic/vmul_issue.sv
      - logic/vmul_simd_mul.sv
      - logic/vmul_result_queue.sv
      - logic/vmul_unit.sv
  - target: test
    files:
      - tests/tb_clk_rst_gen.sv
      - tests/tb_vmul_unit.sv

// File: tests/tb_vmul_unit.sv
module tb_vmul_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import vmul_pkg::*;

  localparam int unsigned NrTests = 16;
  localparam logic [31:0] Seed    = 32'hd642cf21;

  typedef struct {
    string       name;
    vmul_op_e    op;
    vew_e        vew;
    int unsigned vl;
    logic        vm;
    logic        use_scalar;
    elen_t       scalar;
    vaddr_t      vd_base;
    int unsigned seed_idx;
  } row_t;

  typedef struct {
    int unsigned row;
    result_t     res;
    logic        last;
  } exp_t;

  logic clk;
  logic rst_n;

  vmul_operation_t      op_i;
  logic                 op_valid_i;
  logic                 op_ready_o;
  elen_t [2:0]          operand_i;
  logic [2:0]           operand_valid_i;
  logic [2:0]           operand_ready_o;
  strb_t                mask_i;
  logic                 mask_valid_i;
  logic                 mask_ready_o;
  result_t              result_o;
  logic                 result_req_o;
  logic                 result_gnt_i;
  logic [NrVInsn-1:0]   vinsn_done_o;

  row_t            tests [NrTests];
  elen_t           vs1_q[$];
  elen_t           vs2_q[$];
  elen_t           vd_q[$];
  strb_t           mask_q[$];
  exp_t            exp_q[$];
  vmul_operation_t pend_op;
  logic            op_pending;
  logic [31:0]     data_rng;
  logic [31:0]     gnt_rng;
  int unsigned     outstanding;
  int unsigned     cycles;
  int unsigned     limit;
  logic            saw_full;

  tb_clk_rst_gen i_clk_rst_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  vmul_unit DUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .op_i           (op_i),
    .op_valid_i     (op_valid_i),
    .op_ready_o     (op_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .result_o       (result_o),
    .result_req_o   (result_req_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand_word(output elen_t w);
    data_rng = lcg_next(data_rng);
    w[63:32] = data_rng;
    data_rng = lcg_next(data_rng);
    w[31:0]  = data_rng;
  endtask

  // Element-wise low, unsigned high or low plus vd product wrapped to the width
  function automatic elen_t model_word(input vmul_op_e op, input vew_e vew, input logic use_s,
                                       input elen_t s, input elen_t a, input elen_t b,
                                       input elen_t c);
    int unsigned  ew;
    logic [127:0] emask;
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] ec;
    logic [127:0] prod;
    logic [127:0] r;
    elen_t        word;
    ew    = 8 << int'(vew);
    emask = (128'd1 << ew) - 128'd1;
    word  = '0;
    for (int unsigned e = 0; e < 64 / ew; e++) begin
      ea   = use_s ? (128'(s) & emask) : ((128'(a) >> (e * ew)) & emask);
      eb   = (128'(b) >> (e * ew)) & emask;
      ec   = (128'(c) >> (e * ew)) & emask;
      prod = ea * eb;
      case (op)
        VMULHU:  r = (prod >> ew) & emask;
        VMACC:   r = (prod + ec) & emask;
        default: r = prod & emask;
      endcase
      word = word | elen_t'(r << (e * ew));
    end
    return word;
  endfunction

  function automatic strb_t expected_be(input int unsigned elems, input vew_e vew,
                                        input strb_t mask);
    logic [8:0] full;
    full = (9'd1 << (elems << int'(vew))) - 9'd1;
    return full[7:0] & mask;
  endfunction

  function automatic elen_t strobe_to_bits(input strb_t be);
    elen_t bits;
    for (int unsigned b = 0; b < 8; b++) bits[b*8 +: 8] = {8{be[b]}};
    return bits;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act)
      else report_failure($sformatf("Fail %s %s: expected %h, actual %h",
                                    test, field, exp, act));
  endtask

  // Queue the operands and expected writes of one row and offer its operation
  task automatic prepare_row(input int unsigned r);
    row_t        t;
    int unsigned epw;
    int unsigned left;
    int unsigned elems;
    elen_t       a;
    elen_t       b;
    elen_t       c;
    elen_t       w;
    strb_t       m;
    exp_t        e;
    t        = tests[r];
    epw      = 8 >> int'(t.vew);
    left     = t.vl;
    data_rng = Seed + 32'(t.seed_idx) * 32'h0100_0193;
    pend_op.id         = vid_t'(r % NrVInsn);
    pend_op.op         = t.op;
    pend_op.vew        = t.vew;
    pend_op.vl         = vlen_t'(t.vl);
    pend_op.vm         = t.vm;
    pend_op.use_scalar = t.use_scalar;
    pend_op.scalar_op  = t.scalar;
    pend_op.vd_base    = t.vd_base;
    for (int unsigned wi = 0; left != 0; wi++) begin
      elems = (left < epw) ? left : epw;
      a = '0;
      c = '0;
      m = '1;
      rand_word(b);
      vs2_q.push_back(b);
      if (!t.use_scalar) begin
        rand_word(a);
        vs1_q.push_back(a);
      end
      if (t.op == VMACC) begin
        rand_word(c);
        vd_q.push_back(c);
      end
      if (!t.vm) begin
        rand_word(w);
        // One mask bit per element spread over its bytes
        for (int unsigned by = 0; by < 8; by++) m[by] = w[40 + (by >> int'(t.vew))];
        mask_q.push_back(m);
      end
      left        = left - elems;
      e.row       = r;
      e.res.id    = pend_op.id;
      e.res.addr  = t.vd_base + vaddr_t'(wi);
      e.res.wdata = model_word(t.op, t.vew, t.use_scalar, t.scalar, a, b, c);
      e.res.be    = expected_be(elems, t.vew, m);
      e.last      = (left == 0);
      exp_q.push_back(e);
    end
    op_pending = 1'b1;
  endtask

  task automatic check_outputs();
    exp_t               e;
    logic [NrVInsn-1:0] exp_done;
    check_value("queue_occupancy", "op_ready_o", 64'(outstanding < InsnQueueDepth),
                64'(op_ready_o));
    if (!op_ready_o) saw_full = 1'b1;
    if (op_valid_i && op_ready_o) begin
      op_pending  = 1'b0;
      outstanding = outstanding + 1;
    end
    assert (!operand_ready_o[0] || vs1_q.size() != 0)
      else report_failure("vs1 operand consumed while none was offered");
    assert (!operand_ready_o[1] || vs2_q.size() != 0)
      else report_failure("vs2 operand consumed while none was offered");
    assert (!operand_ready_o[2] || vd_q.size() != 0)
      else report_failure("vd operand consumed while none was offered");
    assert (!mask_ready_o || mask_q.size() != 0)
      else report_failure("Mask consumed while none was offered");
    if (operand_ready_o[0]) void'(vs1_q.pop_front());
    if (operand_ready_o[1]) void'(vs2_q.pop_front());
    if (operand_ready_o[2]) void'(vd_q.pop_front());
    if (mask_ready_o) void'(mask_q.pop_front());
    if (result_req_o && result_gnt_i) begin
      assert (exp_q.size() != 0)
        else report_failure("Register-file write with no write expected");
      e        = exp_q.pop_front();
      exp_done = e.last ? (NrVInsn'(1) << e.res.id) : '0;
      check_value(tests[e.row].name, "id", 64'(e.res.id), 64'(result_o.id));
      check_value(tests[e.row].name, "addr", 64'(e.res.addr), 64'(result_o.addr));
      check_value(tests[e.row].name, "be", 64'(e.res.be), 64'(result_o.be));
      check_value(tests[e.row].name, "wdata", e.res.wdata & strobe_to_bits(e.res.be),
                  result_o.wdata & strobe_to_bits(e.res.be));
      check_value(tests[e.row].name, "vinsn_done_o", 64'(exp_done), 64'(vinsn_done_o));
      if (e.last) outstanding = outstanding - 1;
    end else begin
      assert (vinsn_done_o == '0)
        else report_failure("Done pulse raised without a final write grant");
    end
  endtask

  // Drive just after the edge and sample at the falling edge where outputs are settled
  task automatic run_cycle();
    @(posedge clk);
    #1;
    op_valid_i      = op_pending;
    op_i            = pend_op;
    operand_valid_i = {vd_q.size() != 0, vs2_q.size() != 0, vs1_q.size() != 0};
    operand_i[0]    = (vs1_q.size() != 0) ? vs1_q[0] : '0;
    operand_i[1]    = (vs2_q.size() != 0) ? vs2_q[0] : '0;
    operand_i[2]    = (vd_q.size() != 0) ? vd_q[0] : '0;
    mask_valid_i    = (mask_q.size() != 0);
    mask_i          = (mask_q.size() != 0) ? mask_q[0] : '0;
    gnt_rng         = lcg_next(gnt_rng);
    result_gnt_i    = (gnt_rng[31:30] != 2'b00);
    @(negedge clk);
    check_outputs();
    cycles = cycles + 1;
    if (cycles > limit) report_failure("Timeout: writes did not complete in time");
  endtask

  initial begin
    op_i            = '0;
    op_valid_i      = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    pend_op         = '0;
    op_pending      = 1'b0;
    gnt_rng         = Seed;
    outstanding     = 0;
    cycles          = 0;
    saw_full        = 1'b0;

    tests[0]  = '{"vmul_ew8", VMUL, EW8, 20, 1'b1, 1'b0, 64'h0, 10'h000, 1};
    tests[1]  = '{"vmul_ew16", VMUL, EW16, 13, 1'b1, 1'b0, 64'h0, 10'h040, 2};
    tests[2]  = '{"vmul_ew32", VMUL, EW32, 7, 1'b1, 1'b0, 64'h0, 10'h080, 3};
    tests[3]  = '{"vmul_ew64", VMUL, EW64, 5, 1'b1, 1'b0, 64'h0, 10'h0c0, 4};
    tests[4]  = '{"vmulhu_ew8", VMULHU, EW8, 16, 1'b1, 1'b0, 64'h0, 10'h100, 5};
    tests[5]  = '{"vmulhu_ew32", VMULHU, EW32, 9, 1'b1, 1'b0, 64'h0, 10'h140, 6};
    tests[6]  = '{"vmacc_ew16", VMACC, EW16, 12, 1'b1, 1'b0, 64'h0, 10'h180, 7};
    tests[7]  = '{"vmacc_ew64", VMACC, EW64, 3, 1'b1, 1'b0, 64'h0, 10'h1c0, 8};
    tests[8]  = '{"scalar_ew8", VMUL, EW8, 11, 1'b1, 1'b1, 64'ha5, 10'h200, 9};
    tests[9]  = '{"scalar_ew16", VMACC, EW16, 6, 1'b1, 1'b1, 64'h1234, 10'h240, 10};
    tests[10] = '{"scalar_ew32", VMUL, EW32, 5, 1'b1, 1'b1, 64'h9abcdef0, 10'h280, 11};
    tests[11] = '{"scalar_ew64", VMULHU, EW64, 2, 1'b1, 1'b1, 64'hfedcba9876543210,
                  10'h2c0, 12};
    tests[12] = '{"masked_ew8", VMUL, EW8, 29, 1'b0, 1'b0, 64'h0, 10'h300, 13};
    tests[13] = '{"long_ew8", VMUL, EW8, 255, 1'b1, 1'b0, 64'h0, 10'h340, 14};
    tests[14] = '{"masked_vmacc_ew32", VMACC, EW32, 7, 1'b0, 1'b0, 64'h0, 10'h380, 15};
    tests[15] = '{"masked_scalar_ew16", VMUL, EW16, 10, 1'b0, 1'b1, 64'h8001, 10'h3c0, 16};

    // Timeout bound grows with the number of result words
    limit = 200;
    for (int unsigned r = 0; r < NrTests; r++) begin
      limit = limit + 20 * ((tests[r].vl + (8 >> int'(tests[r].vew)) - 1) >>
                            (3 - int'(tests[r].vew)));
    end

    wait (rst_n === 1'b1);
    @(negedge clk);
    assert (op_ready_o && !result_req_o && vinsn_done_o == '0 &&
            operand_ready_o == '0 && !mask_ready_o)
      else report_failure("Control outputs wrong after reset");

    for (int unsigned r = 0; r < NrTests; r++) begin
      prepare_row(r);
      while (op_pending) run_cycle();
    end
    while (exp_q.size() != 0) run_cycle();
    // Idle cycles catch stray writes or done pulses
    repeat (5) run_cycle();

    if (saw_full && vs1_q.size() == 0 && vs2_q.size() == 0 && vd_q.size() == 0 &&
        mask_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure("op_ready_o never dropped or operands were left unconsumed");
    end
  end

endmodule

// File: tests/tb_clk_rst_gen.sv
module tb_clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam realtime     ClkHalfPeriod = 2ns;
  localparam int unsigned RstCycles     = 8;

  initial begin
    clk_o = 1'b0;
    forever #(ClkHalfPeriod) clk_o = ~clk_o;
  end

  // Release lines up with the input drive point after the edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: logic/vmul_unit.sv
module vmul_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  vmul_pkg::vmul_operation_t    op_i,
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  vmul_pkg::elen_t [2:0]        operand_i,
  input  logic [2:0]                   operand_valid_i,
  output logic [2:0]                   operand_ready_o,
  input  vmul_pkg::strb_t              mask_i,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  output vmul_pkg::result_t            result_o,
  output logic                         result_req_o,
  input  logic                         result_gnt_i,
  output logic [vmul_pkg::NrVInsn-1:0] vinsn_done_o
);

  import vmul_pkg::*;

  vmul_operation_t issue_op;
  logic            issue_valid;
  vlen_t           issue_cnt;
  logic            issue_word_done;
  logic            issue_insn_done;
  vmul_operation_t proc_op;
  vlen_t           proc_cnt;
  logic            proc_word_done;
  logic            proc_insn_done;
  logic            commit_insn_done;

  mul_req_t  mul_req;
  logic      mul_req_valid;
  logic      mul_req_ready;
  mul_resp_t mul_resp;
  logic      mul_resp_valid;
  logic      mul_resp_ready;

  vmul_insn_queue i_insn_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .op_i              (op_i),
    .op_valid_i        (op_valid_i),
    .op_ready_o        (op_ready_o),
    .issue_op_o        (issue_op),
    .issue_valid_o     (issue_valid),
    .issue_cnt_o       (issue_cnt),
    .issue_word_done_i (issue_word_done),
    .issue_insn_done_i (issue_insn_done),
    .proc_op_o         (proc_op),
    .proc_cnt_o        (proc_cnt),
    .proc_word_done_i  (proc_word_done),
    .proc_insn_done_i  (proc_insn_done),
    .commit_insn_done_i(commit_insn_done),
    .vinsn_done_o      (vinsn_done_o)
  );

  vmul_issue i_issue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_op_i       (issue_op),
    .issue_valid_i    (issue_valid),
    .issue_cnt_i      (issue_cnt),
    .operand_i        (operand_i),
    .operand_valid_i  (operand_valid_i),
    .operand_ready_o  (operand_ready_o),
    .mask_i           (mask_i),
    .mask_valid_i     (mask_valid_i),
    .mask_ready_o     (mask_ready_o),
    .req_o            (mul_req),
    .req_valid_o      (mul_req_valid),
    .req_ready_i      (mul_req_ready),
    .issue_word_done_o(issue_word_done),
    .issue_insn_done_o(issue_insn_done)
  );

  vmul_simd_mul i_simd_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (mul_req),
    .req_valid_i (mul_req_valid),
    .req_ready_o (mul_req_ready),
    .resp_o      (mul_resp),
    .resp_valid_o(mul_resp_valid),
    .resp_ready_i(mul_resp_ready)
  );

  vmul_result_queue i_result_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .resp_i            (mul_resp),
    .resp_valid_i      (mul_resp_valid),
    .resp_ready_o      (mul_resp_ready),
    .proc_op_i         (proc_op),
    .proc_cnt_i        (proc_cnt),
    .proc_word_done_o  (proc_word_done),
    .proc_insn_done_o  (proc_insn_done),
    .result_o          (result_o),
    .result_req_o      (result_req_o),
    .result_gnt_i      (result_gnt_i),
    .commit_insn_done_o(commit_insn_done)
  );

endmodule

// File: logic/vmul_result_queue.sv
module vmul_result_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::mul_resp_t       resp_i,
  input  logic                      resp_valid_i,
  output logic                      resp_ready_o,
  input  vmul_pkg::vmul_operation_t proc_op_i,
  input  vmul_pkg::vlen_t           proc_cnt_i,
  output logic                      proc_word_done_o,
  output logic                      proc_insn_done_o,
  output vmul_pkg::result_t         result_o,
  output logic                      result_req_o,
  input  logic                      result_gnt_i,
  output logic                      commit_insn_done_o
);

  import vmul_pkg::*;

  result_t [ResultQueueDepth-1:0] buf_q;
  // Marks the final word of an instruction
  logic    [ResultQueueDepth-1:0] last_q;
  rq_pnt_t                        wr_pnt_q;
  rq_pnt_t                        rd_pnt_q;
  rq_cnt_t                        cnt_q;

  vlen_t   proc_elems;
  vlen_t   done_elems;
  vlen_t   word_idx;
  result_t entry;
  logic    write;
  logic    pop;

  assign resp_ready_o = (cnt_q != rq_cnt_t'(ResultQueueDepth));
  assign write        = resp_valid_i && resp_ready_o;

  assign proc_elems = word_elems_fn(proc_cnt_i, proc_op_i.vew);
  assign done_elems = proc_op_i.vl - proc_cnt_i;
  assign word_idx   = done_elems >> (int'(EW64) - int'(proc_op_i.vew));

  always_comb begin
    entry.id    = proc_op_i.id;
    entry.addr  = proc_op_i.vd_base + vaddr_t'(word_idx);
    entry.wdata = resp_i.result;
    entry.be    = be_fn(proc_elems, proc_op_i.vew) & resp_i.mask;
  end

  assign proc_word_done_o = write;
  assign proc_insn_done_o = write && (proc_elems == proc_cnt_i);

  assign result_req_o       = (cnt_q != '0);
  assign result_o           = buf_q[rd_pnt_q];
  assign pop                = result_req_o && result_gnt_i;
  assign commit_insn_done_o = pop && last_q[rd_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (write) wr_pnt_q <= wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= rd_pnt_q + 1'b1;
      case ({write, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      buf_q[wr_pnt_q]  <= entry;
      last_q[wr_pnt_q] <= proc_insn_done_o;
    end
  end

endmodule

// File: logic/vmul_simd_mul.sv
module vmul_simd_mul (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vmul_pkg::mul_req_t  req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output vmul_pkg::mul_resp_t resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i
);

  import vmul_pkg::*;

  // Full-word result for each element width
  elen_t [3:0] ew_res;

  mul_resp_t [MulLatency-1:0] in_data;
  mul_resp_t [MulLatency-1:0] data_q;
  logic      [MulLatency-1:0] in_valid;
  logic      [MulLatency-1:0] valid_q;
  logic      [MulLatency-1:0] stage_ready;

  for (genvar w = 0; w < 4; w++) begin : gen_ew
    localparam int unsigned EW = 8 << w;

    for (genvar e = 0; e < ElenWidth / EW; e++) begin : gen_elem
      logic [EW-1:0]   a;
      logic [EW-1:0]   b;
      logic [EW-1:0]   c;
      logic [2*EW-1:0] prod;

      assign a    = req_i.operand_a[e*EW +: EW];
      assign b    = req_i.operand_b[e*EW +: EW];
      assign c    = req_i.operand_c[e*EW +: EW];
      assign prod = a * b;

      // Sums wrap to the element width
      assign ew_res[w][e*EW +: EW] = (req_i.op == VMULHU) ? prod[2*EW-1:EW] :
                                     (req_i.op == VMACC)  ? prod[EW-1:0] + c :
                                                            prod[EW-1:0];
    end
  end

  always_comb begin
    in_valid[0]       = req_valid_i;
    in_data[0].result = ew_res[req_i.vew];
    in_data[0].mask   = req_i.mask;
    for (int s = 1; s < MulLatency; s++) begin
      in_valid[s] = valid_q[s-1];
      in_data[s]  = data_q[s-1];
    end
  end

  for (genvar s = 0; s < MulLatency; s++) begin : gen_stage
    // A stage takes new data when empty or when it drains this cycle
    if (s == MulLatency - 1) begin : gen_last
      assign stage_ready[s] = !valid_q[s] || resp_ready_i;
    end else begin : gen_mid
      assign stage_ready[s] = !valid_q[s] || stage_ready[s+1];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[s] <= 1'b0;
      end else if (stage_ready[s]) begin
        valid_q[s] <= in_valid[s];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[s] && in_valid[s]) begin
        data_q[s] <= in_data[s];
      end
    end
  end

  assign req_ready_o  = stage_ready[0];
  assign resp_o       = data_q[MulLatency-1];
  assign resp_valid_o = valid_q[MulLatency-1];

endmodule

// File: logic/vmul_issue.sv
module vmul_issue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::vmul_operation_t issue_op_i,
  input  logic                      issue_valid_i,
  input  vmul_pkg::vlen_t           issue_cnt_i,
  input  vmul_pkg::elen_t [2:0]     operand_i,
  input  logic [2:0]                operand_valid_i,
  output logic [2:0]                operand_ready_o,
  input  vmul_pkg::strb_t           mask_i,
  input  logic                      mask_valid_i,
  output logic                      mask_ready_o,
  output vmul_pkg::mul_req_t        req_o,
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output logic                      issue_word_done_o,
  output logic                      issue_insn_done_o
);

  import vmul_pkg::*;

  vmul_operation_t op_q;
  elen_t           scalar_rep;
  logic [2:0]      use_src;
  logic            srcs_valid;
  vlen_t           issue_elems;
  logic            handshake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= '0;
    end else begin
      op_q <= issue_op_i;
    end
  end

  // Scalar copied into every element slot of the word
  always_comb begin
    scalar_rep = op_q.scalar_op;
    case (op_q.vew)
      EW8:  scalar_rep = {8{op_q.scalar_op[7:0]}};
      EW16: scalar_rep = {4{op_q.scalar_op[15:0]}};
      EW32: scalar_rep = {2{op_q.scalar_op[31:0]}};
      EW64: scalar_rep = op_q.scalar_op;
      default: ;
    endcase
  end

  // Sources in use in the order vd, vs2, vs1
  assign use_src    = {op_q.op == VMACC, 1'b1, !op_q.use_scalar};
  assign srcs_valid = (&(operand_valid_i | ~use_src)) && (mask_valid_i || op_q.vm);

  assign issue_elems = word_elems_fn(issue_cnt_i, op_q.vew);
  assign req_valid_o = issue_valid_i && srcs_valid;
  assign handshake   = req_valid_o && req_ready_i;

  always_comb begin
    req_o.operand_a = op_q.use_scalar ? scalar_rep : operand_i[0];
    req_o.operand_b = operand_i[1];
    req_o.operand_c = operand_i[2];
    req_o.op        = op_q.op;
    req_o.vew       = op_q.vew;
    // Inactive elements travel with a cleared strobe
    req_o.mask      = be_fn(issue_elems, op_q.vew) & (op_q.vm ? {StrbWidth{1'b1}} : mask_i);
  end

  assign operand_ready_o   = handshake ? use_src : 3'b000;
  assign mask_ready_o      = handshake && !op_q.vm;
  assign issue_word_done_o = handshake;
  assign issue_insn_done_o = handshake && (issue_elems == issue_cnt_i);

endmodule

// File: logic/vmul_insn_queue.sv
module vmul_insn_queue (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  vmul_pkg::vmul_operation_t      op_i,
  input  logic                           op_valid_i,
  output logic                           op_ready_o,
  output vmul_pkg::vmul_operation_t      issue_op_o,
  output logic                           issue_valid_o,
  output vmul_pkg::vlen_t                issue_cnt_o,
  input  logic                           issue_word_done_i,
  input  logic                           issue_insn_done_i,
  output vmul_pkg::vmul_operation_t      proc_op_o,
  output vmul_pkg::vlen_t                proc_cnt_o,
  input  logic                           proc_word_done_i,
  input  logic                           proc_insn_done_i,
  input  logic                           commit_insn_done_i,
  output logic [vmul_pkg::NrVInsn-1:0]   vinsn_done_o
);

  import vmul_pkg::*;

  vmul_operation_t [InsnQueueDepth-1:0] vinsn_d, vinsn_q;

  // One pointer per execution phase
  insn_pnt_t accept_pnt_d, accept_pnt_q;
  insn_pnt_t issue_pnt_d, issue_pnt_q;
  insn_pnt_t proc_pnt_d, proc_pnt_q;
  insn_pnt_t commit_pnt_d, commit_pnt_q;

  // Instructions still waiting in each phase
  insn_cnt_t issue_n_d, issue_n_q;
  insn_cnt_t proc_n_d, proc_n_q;
  insn_cnt_t commit_n_d, commit_n_q;

  // Remaining elements of the head instruction of issue and processing
  vlen_t issue_cnt_d, issue_cnt_q;
  vlen_t proc_cnt_d, proc_cnt_q;

  logic accept;

  assign op_ready_o = (commit_n_q != insn_cnt_t'(InsnQueueDepth));
  assign accept     = op_valid_i && op_ready_o;

  always_comb begin
    vinsn_d      = vinsn_q;
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    proc_pnt_d   = proc_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_n_d    = issue_n_q;
    proc_n_d     = proc_n_q;
    commit_n_d   = commit_n_q;
    issue_cnt_d  = issue_cnt_q;
    proc_cnt_d   = proc_cnt_q;
    vinsn_done_o = '0;

    if (issue_word_done_i) begin
      issue_cnt_d = issue_cnt_q - word_elems_fn(issue_cnt_q, vinsn_q[issue_pnt_q].vew);
    end
    if (issue_insn_done_i) begin
      issue_n_d   = issue_n_q - 1'b1;
      issue_pnt_d = issue_pnt_q + 1'b1;
      // Next instruction is already stored if any is left
      if (issue_n_d != '0) issue_cnt_d = vinsn_q[issue_pnt_d].vl;
    end

    if (proc_word_done_i) begin
      proc_cnt_d = proc_cnt_q - word_elems_fn(proc_cnt_q, vinsn_q[proc_pnt_q].vew);
    end
    if (proc_insn_done_i) begin
      proc_n_d   = proc_n_q - 1'b1;
      proc_pnt_d = proc_pnt_q + 1'b1;
      if (proc_n_d != '0) proc_cnt_d = vinsn_q[proc_pnt_d].vl;
    end

    if (commit_insn_done_i) begin
      vinsn_done_o[vinsn_q[commit_pnt_q].id] = 1'b1;
      commit_n_d   = commit_n_q - 1'b1;
      commit_pnt_d = commit_pnt_q + 1'b1;
    end

    if (accept) begin
      vinsn_d[accept_pnt_q] = op_i;
      accept_pnt_d          = accept_pnt_q + 1'b1;
      // An idle phase starts counting on the new instruction
      if (issue_n_d == '0) issue_cnt_d = op_i.vl;
      if (proc_n_d == '0) proc_cnt_d = op_i.vl;
      issue_n_d  = issue_n_d + 1'b1;
      proc_n_d   = proc_n_d + 1'b1;
      commit_n_d = commit_n_d + 1'b1;
    end
  end

  // Issue stage registers this, so it lines up with issue_pnt_q
  assign issue_op_o    = vinsn_d[issue_pnt_d];
  assign issue_valid_o = (issue_n_q != '0);
  assign issue_cnt_o   = issue_cnt_q;
  assign proc_op_o     = vinsn_q[proc_pnt_q];
  assign proc_cnt_o    = proc_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vinsn_q      <= '0;
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_n_q    <= '0;
      proc_n_q     <= '0;
      commit_n_q   <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
    end else begin
      vinsn_q      <= vinsn_d;
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      proc_pnt_q   <= proc_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_n_q    <= issue_n_d;
      proc_n_q     <= proc_n_d;
      commit_n_q   <= commit_n_d;
      issue_cnt_q  <= issue_cnt_d;
      proc_cnt_q   <= proc_cnt_d;
    end
  end

endmodule

// File: logic/vmul_pkg.sv
package vmul_pkg;

  // Datapath and bookkeeping sizes
  localparam int unsigned ElenWidth        = 64;
  localparam int unsigned StrbWidth        = ElenWidth / 8;
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned VlWidth          = 8;
  localparam int unsigned AddrWidth        = 10;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned MulLatency       = 2;

  // Pointer and occupancy widths of the two queues
  localparam int unsigned InsnPntWidth   = $clog2(InsnQueueDepth);
  localparam int unsigned ResultPntWidth = $clog2(ResultQueueDepth);

  typedef logic [ElenWidth-1:0]      elen_t;
  typedef logic [StrbWidth-1:0]      strb_t;
  typedef logic [VlWidth-1:0]        vlen_t;
  typedef logic [AddrWidth-1:0]      vaddr_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  typedef logic [InsnPntWidth-1:0]   insn_pnt_t;
  typedef logic [InsnPntWidth:0]     insn_cnt_t;
  typedef logic [ResultPntWidth-1:0] rq_pnt_t;
  typedef logic [ResultPntWidth:0]   rq_cnt_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULHU = 2'd1,
    VMACC  = 2'd2
  } vmul_op_e;

  typedef struct packed {
    vid_t     id;
    vmul_op_e op;
    vew_e     vew;
    vlen_t    vl;
    // Unmasked when set
    logic     vm;
    logic     use_scalar;
    elen_t    scalar_op;
    vaddr_t   vd_base;
  } vmul_operation_t;

  typedef struct packed {
    elen_t    operand_a;
    elen_t    operand_b;
    elen_t    operand_c;
    vmul_op_e op;
    vew_e     vew;
    strb_t    mask;
  } mul_req_t;

  typedef struct packed {
    elen_t result;
    strb_t mask;
  } mul_resp_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Elements carried by the next word out of the cnt still left
  function automatic vlen_t word_elems_fn(input vlen_t cnt, input vew_e vew);
    vlen_t per_word;
    per_word = vlen_t'(StrbWidth >> int'(vew));
    return (cnt < per_word) ? cnt : per_word;
  endfunction

  // Byte enable of a word holding elems valid elements of width vew
  function automatic strb_t be_fn(input vlen_t elems, input vew_e vew);
    int unsigned nbytes;
    strb_t       be;
    nbytes = int'(elems) << int'(vew);
    be     = '0;
    for (int unsigned b = 0; b < StrbWidth; b++) begin
      if (b < nbytes) be[b] = 1'b1;
    end
    return be;
  endfunction

endpackage
